// File: sum_kernel.f
logic/sum_kernel_pkg.sv
logic/vertex_job_queue.sv
logic/edge_stream_accumulator.sv
logic/vertex_writeback.sv
logic/sum_kernel_unit.sv
bench/sum_kernel_properties.sv
bench/sum_kernel_tb.sv

// File: Bender.yml
package:
  name: sum_kernel

sources:
  - logic/sum_kernel_pkg.sv
  - logic/vertex_job_queue.sv
  - logic/edge_stream_accumulator.sv
  - logic/vertex_writeback.sv
  - logic/sum_kernel_unit.sv
  - target: test
    files:
      - bench/sum_kernel_properties.sv
      - bench/sum_kernel_tb.sv

// File: bench/sum_kernel_tb.sv
`timescale 1ns/10ps

module sum_kernel_tb;

	localparam int ROWS = 11;
	localparam int MAX_DEG = 6;
	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;
	localparam logic [63:0] BASE = 64'h0000_1000_2000_0000;

	// one vertex of the stimulus table
	typedef struct packed {
		logic [31:0] id;
		logic [31:0] degree;
		logic        throttle;
		logic        ahead;
	} row_t;

	logic                           clock;
	logic                           rstn;
	logic                           enabled_in;
	sum_kernel_pkg::wed_t           wed_request_in;
	sum_kernel_pkg::vertex_job_t    vertex_job;
	sum_kernel_pkg::edge_data_t     edge_data;
	sum_kernel_pkg::buffer_status_t data_buffer_status;
	sum_kernel_pkg::buffer_status_t write_buffer_status;
	logic                           edge_data_request;
	sum_kernel_pkg::write_command_t write_command_out;
	sum_kernel_pkg::write_data_t    write_data_out;
	logic                           job_queue_full;

	row_t        table_rows [ROWS];
	logic [31:0] edge_val [ROWS][MAX_DEG];
	logic [31:0] exp_sum [ROWS];
	sum_kernel_pkg::write_command_t exp_cmd_q [$];
	sum_kernel_pkg::write_data_t    exp_data_q [$];
	logic [31:0] lfsr_state;
	// request level seen in the previous cycle
	logic        req_seen;

	sum_kernel_unit u_sum_kernel_unit (.*);

	bind sum_kernel_unit sum_kernel_properties u_sum_kernel_properties (.*);

	always #20 clock = ~clock;

	////////////////////////////////////////////////////////////
	// random edge values
	////////////////////////////////////////////////////////////

	// galois form with taps of x^32+x^22+x^2+x+1
	function logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return b;
	endfunction

	function logic [31:0] lfsr_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++)
			w[i] = lfsr_bit();
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task stop_run();
		$display("Something failed");
		$fatal(1);
	endtask

	task check_command(string name, sum_kernel_pkg::write_command_t exp,
		sum_kernel_pkg::write_command_t got);
		if (exp !== got) begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
			stop_run();
		end
	endtask

	task check_data(string name, sum_kernel_pkg::write_data_t exp,
		sum_kernel_pkg::write_data_t got);
		if (exp !== got) begin
			$display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
			stop_run();
		end
	endtask

	task check_level(string name, logic exp, logic got);
		if (exp !== got) begin
			$display("Fail at %0t: %s expected %b got %b", $time, name, exp, got);
			stop_run();
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clock) begin
		if (!rstn) begin
			req_seen = 1'b0;
		end else begin
			req_seen = edge_data_request;
			if (write_buffer_status.almost_full)
				check_level("edge_data_request", 1'b0, edge_data_request);
			if (write_command_out.valid && exp_cmd_q.size() == 0) begin
				$display("a write appeared with no job waiting for it");
				stop_run();
			end else if (write_command_out.valid) begin
				check_command("write_command_out", exp_cmd_q.pop_front(), write_command_out);
				check_data("write_data_out", exp_data_q.pop_front(), write_data_out);
			end else begin
				// data line never goes out alone
				check_level("write_data_out.valid", 1'b0, write_data_out.valid);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// drive
	////////////////////////////////////////////////////////////

	task idle_cycle();
		@(posedge clock);
		vertex_job <= '0;
		edge_data  <= '0;
	endtask

	// push one job and queue its expected write
	task push_job(int r);
		int waited;
		waited = 0;
		@(negedge clock);
		while (job_queue_full && waited < WAIT_LIMIT) begin
			waited++;
			idle_cycle();
			@(negedge clock);
		end
		if (job_queue_full) begin
			$display("the job queue never drained");
			stop_run();
		end else begin
			@(posedge clock);
			vertex_job <= {1'b1, table_rows[r].id, table_rows[r].degree};
			edge_data  <= '0;
			exp_cmd_q.push_back({1'b1, BASE + 64'(table_rows[r].id) * 64'd4,
				8'd4, 8'd1, table_rows[r].id});
			exp_data_q.push_back({1'b1, table_rows[r].id, exp_sum[r]});
		end
	endtask

	// one edge per cycle and only after a request cycle
	task feed_edges(int r);
		int k;
		int cycles;
		k = 0;
		cycles = 0;
		while (k < int'(table_rows[r].degree) && cycles < WAIT_LIMIT) begin
			@(posedge clock);
			vertex_job <= '0;
			// throttled rows hold the write buffer near full a while
			write_buffer_status.almost_full <= table_rows[r].throttle && cycles < 6;
			if (req_seen) begin
				edge_data <= {1'b1, edge_val[r][k]};
				k++;
			end else begin
				edge_data <= '0;
			end
			cycles++;
		end
		if (k < int'(table_rows[r].degree)) begin
			$display("edges were never requested for vertex %0d", table_rows[r].id);
			stop_run();
		end
	endtask

	// wait until only left writes are still outstanding
	task wait_for_writes(int left);
		int cycles;
		cycles = 0;
		idle_cycle();
		@(negedge clock);
		#1;
		while (exp_cmd_q.size() > left && cycles < WAIT_LIMIT) begin
			@(negedge clock);
			#1;
			cycles++;
		end
		if (exp_cmd_q.size() > left) begin
			$display("no write command appeared");
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////

	initial begin
		clock               = 1'b0;
		rstn                = 1'b0;
		enabled_in          = 1'b0;
		wed_request_in      = '0;
		vertex_job          = '0;
		edge_data           = '0;
		data_buffer_status  = '0;
		write_buffer_status = '0;
		lfsr_state          = 32'h754f7da6;

		// id, degree, throttle, queued ahead
		table_rows[0]  = '{32'd5, 32'd3, 1'b0, 1'b0};
		table_rows[1]  = '{32'd9, 32'd1, 1'b0, 1'b0};
		table_rows[2]  = '{32'd12, 32'd0, 1'b0, 1'b0};
		table_rows[3]  = '{32'd3, 32'd6, 1'b0, 1'b0};
		table_rows[4]  = '{32'd7, 32'd4, 1'b1, 1'b0};
		table_rows[5]  = '{32'd20, 32'd0, 1'b0, 1'b0};
		table_rows[6]  = '{32'd21, 32'd2, 1'b0, 1'b0};
		table_rows[7]  = '{32'd40, 32'd2, 1'b0, 1'b1};
		table_rows[8]  = '{32'd41, 32'd3, 1'b0, 1'b1};
		table_rows[9]  = '{32'd42, 32'd1, 1'b0, 1'b1};
		table_rows[10] = '{32'd43, 32'd5, 1'b0, 1'b1};

		// wrapped totals per vertex
		for (int r = 0; r < ROWS; r++) begin
			exp_sum[r] = '0;
			for (int k = 0; k < int'(table_rows[r].degree); k++) begin
				edge_val[r][k] = lfsr_word();
				exp_sum[r]     = exp_sum[r] + edge_val[r][k];
			end
		end

		repeat (8) @(posedge clock);
		rstn <= 1'b1;

		// nothing may move while still disabled
		repeat (4) begin
			@(negedge clock);
			check_level("edge_data_request", 1'b0, edge_data_request);
		end

		@(posedge clock);
		enabled_in     <= 1'b1;
		wed_request_in <= {1'b1, BASE};
		@(posedge clock);
		wed_request_in.valid <= 1'b0;

		// each job then its edges with the next job straight after
		for (int r = 0; r < ROWS; r++) begin
			if (!table_rows[r].ahead) begin
				push_job(r);
				feed_edges(r);
			end
		end
		wait_for_writes(0);

		// jobs ahead of their edges fill the queue
		for (int r = 0; r < ROWS; r++) begin
			if (table_rows[r].ahead)
				push_job(r);
		end
		idle_cycle();
		@(negedge clock);
		check_level("job_queue_full", 1'b1, job_queue_full);

		for (int r = 0; r < ROWS; r++) begin
			if (table_rows[r].ahead) begin
				feed_edges(r);
				if (r == 7) begin
					wait_for_writes(3);
					check_level("job_queue_full", 1'b0, job_queue_full);
				end
			end
		end
		wait_for_writes(0);

		repeat (3) idle_cycle();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: bench/sum_kernel_properties.sv
`timescale 1ns/10ps

module sum_kernel_properties (
	input logic                           clock,
	input logic                           rstn,
	input sum_kernel_pkg::vertex_job_t    vertex_job,
	input logic                           vertex_done,
	input sum_kernel_pkg::buffer_status_t write_buffer_status,
	input logic                           edge_data_request,
	input sum_kernel_pkg::write_command_t write_command_out,
	input sum_kernel_pkg::write_data_t    write_data_out,
	input logic                           job_queue_full
);

	////////////////////////////////////////////////////////////
	// write outputs
	////////////////////////////////////////////////////////////

	// command and data line go out as a pair
	valid_pair: assert property (@(posedge clock) disable iff (!rstn)
		write_command_out.valid == write_data_out.valid)
		else $error("write command and data valid differ");

	// one pulse per vertex, a new vertex may follow at once
	one_cycle_pulse: assert property (@(posedge clock) disable iff (!rstn)
		write_command_out.valid |=> (!write_command_out.valid ||
			write_command_out.vertex_id != $past(write_command_out.vertex_id)))
		else $error("write command held for the same vertex");

	////////////////////////////////////////////////////////////
	// flow control
	////////////////////////////////////////////////////////////

	// back-pressure stops new edges
	no_request_when_full: assert property (@(posedge clock) disable iff (!rstn)
		write_buffer_status.almost_full |-> !edge_data_request)
		else $error("edge request while write buffer almost full");

	// a pop with no push frees an entry
	pop_clears_full: assert property (@(posedge clock) disable iff (!rstn)
		(vertex_done && !vertex_job.valid) |=> !job_queue_full)
		else $error("job queue full right after a pop");

endmodule

// File: logic/sum_kernel_unit.sv
`timescale 1ns/10ps

module sum_kernel_unit (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  sum_kernel_pkg::wed_t           wed_request_in,
	input  sum_kernel_pkg::vertex_job_t    vertex_job,
	input  sum_kernel_pkg::edge_data_t     edge_data,
	input  sum_kernel_pkg::buffer_status_t data_buffer_status,
	input  sum_kernel_pkg::buffer_status_t write_buffer_status,
	output logic                           edge_data_request,
	output sum_kernel_pkg::write_command_t write_command_out,
	output sum_kernel_pkg::write_data_t    write_data_out,
	output logic                           job_queue_full
);

	// registered enable from the accumulator
	logic enabled;
	// completion pulse, pops the queue and restarts the sum
	logic vertex_done;

	sum_kernel_pkg::vertex_job_t  head_job;
	sum_kernel_pkg::accum_state_t accum_state;

	// base of the result array from the descriptor
	logic [sum_kernel_pkg::ADDR_BITS-1:0] result_base;

	////////////////////////////////////////////////////////////
	// descriptor latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			result_base <= '0;
		else if (wed_request_in.valid)
			result_base <= wed_request_in.result_base;
	end

	////////////////////////////////////////////////////////////
	// edge request
	////////////////////////////////////////////////////////////

	// almost full leaves room for writes in flight
	// so only new edges are held back
	assign edge_data_request = enabled & ~data_buffer_status.empty &
		~write_buffer_status.almost_full;

	////////////////////////////////////////////////////////////
	// blocks
	////////////////////////////////////////////////////////////

	vertex_job_queue u_vertex_job_queue (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_job     (vertex_job),
		.vertex_done    (vertex_done),
		.head_job       (head_job),
		.job_queue_full (job_queue_full)
	);

	edge_stream_accumulator u_edge_stream_accumulator (
		.clock       (clock),
		.rstn        (rstn),
		.enabled_in  (enabled_in),
		.edge_data   (edge_data),
		.vertex_done (vertex_done),
		.enabled     (enabled),
		.accum_state (accum_state)
	);

	vertex_writeback u_vertex_writeback (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.head_job          (head_job),
		.accum_state       (accum_state),
		.result_base       (result_base),
		.vertex_done       (vertex_done),
		.write_command_out (write_command_out),
		.write_data_out    (write_data_out)
	);

endmodule

// File: logic/vertex_writeback.sv
`timescale 1ns/10ps

module vertex_writeback (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   enabled,
	input  sum_kernel_pkg::vertex_job_t            head_job,
	input  sum_kernel_pkg::accum_state_t           accum_state,
	input  logic [sum_kernel_pkg::ADDR_BITS-1:0]   result_base,
	output logic                                   vertex_done,
	output sum_kernel_pkg::write_command_t         write_command_out,
	output sum_kernel_pkg::write_data_t            write_data_out
);

	// entry address of the head vertex
	logic [sum_kernel_pkg::ADDR_BITS-1:0] id_wide;
	logic [sum_kernel_pkg::ADDR_BITS-1:0] byte_offset;
	logic [sum_kernel_pkg::ADDR_BITS-1:0] write_address;

	////////////////////////////////////////////////////////////
	// completion
	////////////////////////////////////////////////////////////

	// all edges of the head vertex are in the sum
	// degree zero matches straight away with count zero
	assign vertex_done = enabled & head_job.valid & (accum_state.count == head_job.degree);

	////////////////////////////////////////////////////////////
	// address
	////////////////////////////////////////////////////////////

	// widen first so large ids keep their top bits
	assign id_wide       = sum_kernel_pkg::ADDR_BITS'(head_job.id);
	assign byte_offset   = id_wide << sum_kernel_pkg::DATA_SHIFT;
	assign write_address = result_base + byte_offset;

	////////////////////////////////////////////////////////////
	// write command and data line
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command_out <= '0;
			write_data_out    <= '0;
		end else begin
			// single cycle pulse per vertex
			write_command_out.valid <= vertex_done;
			write_data_out.valid    <= vertex_done;

			if (vertex_done) begin
				write_command_out.address   <= write_address;
				write_command_out.size      <=
					sum_kernel_pkg::SIZE_BITS'(sum_kernel_pkg::DATA_SIZE_BYTES);
				write_command_out.cu_id     <= sum_kernel_pkg::CU_ID;
				write_command_out.vertex_id <= head_job.id;

				// one line holds the whole result
				write_data_out.vertex_id <= head_job.id;
				write_data_out.sum       <= accum_state.sum;
			end
		end
	end

endmodule

// File: logic/edge_stream_accumulator.sv
`timescale 1ns/10ps

module edge_stream_accumulator (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled_in,
	input  sum_kernel_pkg::edge_data_t   edge_data,
	input  logic                         vertex_done,
	output logic                         enabled,
	output sum_kernel_pkg::accum_state_t accum_state
);

	// edge held for one cycle before the add
	sum_kernel_pkg::edge_data_t edge_latched;

	////////////////////////////////////////////////////////////
	// enable register
	////////////////////////////////////////////////////////////

	// enable lands one cycle after enabled_in
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	////////////////////////////////////////////////////////////
	// edge latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_latched <= '0;
		end else if (enabled) begin
			// store zero on idle cycles so the add is harmless
			if (edge_data.valid)
				edge_latched <= edge_data;
			else
				edge_latched <= '0;
		end
	end

	////////////////////////////////////////////////////////////
	// running sum and count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			accum_state <= '0;
		end else if (enabled) begin
			if (vertex_done) begin
				// restart, an edge latched now belongs to the next vertex
				accum_state.sum   <= edge_latched.data;
				accum_state.count <= sum_kernel_pkg::ID_BITS'(edge_latched.valid);
			end else if (edge_latched.valid) begin
				accum_state.sum   <= accum_state.sum + edge_latched.data;
				accum_state.count <= accum_state.count + 1'b1;
			end
		end
	end

endmodule

// File: logic/vertex_job_queue.sv
`timescale 1ns/10ps

module vertex_job_queue (
	input  logic                        clock,
	input  logic                        rstn,
	input  sum_kernel_pkg::vertex_job_t vertex_job,
	input  logic                        vertex_done,
	output sum_kernel_pkg::vertex_job_t head_job,
	output logic                        job_queue_full
);

	// storage, no reset needed
	sum_kernel_pkg::vertex_job_t job_mem [sum_kernel_pkg::JOB_DEPTH];

	logic [sum_kernel_pkg::JOB_PTR_BITS-1:0] wr_ptr;
	logic [sum_kernel_pkg::JOB_PTR_BITS-1:0] rd_ptr;
	logic [sum_kernel_pkg::JOB_CNT_BITS-1:0] occupancy;

	logic push;
	logic pop;
	logic empty;

	////////////////////////////////////////////////////////////
	// status
	////////////////////////////////////////////////////////////

	assign empty          = (occupancy == '0);
	assign job_queue_full =
		(occupancy == sum_kernel_pkg::JOB_CNT_BITS'(sum_kernel_pkg::JOB_DEPTH));

	// source holds off while full, the gate is a safety net
	assign push = vertex_job.valid & ~job_queue_full;
	// done only fires on a valid head, still guard the pop
	assign pop  = vertex_done & ~empty;

	////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
		end else begin
			if (push) begin
				// wrap at the last entry
				if (wr_ptr == sum_kernel_pkg::JOB_PTR_BITS'(sum_kernel_pkg::JOB_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				if (rd_ptr == sum_kernel_pkg::JOB_PTR_BITS'(sum_kernel_pkg::JOB_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (push && !pop)
				occupancy <= occupancy + 1'b1;
			else if (pop && !push)
				occupancy <= occupancy - 1'b1;
		end
	end

	// entry write
	always_ff @(posedge clock) begin
		if (push)
			job_mem[wr_ptr] <= vertex_job;
	end

	////////////////////////////////////////////////////////////
	// head presentation
	////////////////////////////////////////////////////////////

	// valid only when something is queued
	always_comb begin
		head_job       = job_mem[rd_ptr];
		head_job.valid = ~empty;
	end

endmodule

// File: logic/sum_kernel_pkg.sv
package sum_kernel_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// edge values and running sums
	localparam int DATA_BITS = 32;
	// vertex ids and out-degrees
	localparam int ID_BITS = 32;
	// host memory addresses
	localparam int ADDR_BITS = 64;
	// size field of a write command
	localparam int SIZE_BITS = 8;
	// compute unit tag in a write command
	localparam int CU_BITS = 8;

	////////////////////////////////////////////////////////////
	// result array layout
	////////////////////////////////////////////////////////////

	// one result entry per vertex
	localparam int DATA_SIZE_BYTES = 4;
	// byte offset of a vertex = id shifted by this
	localparam int DATA_SHIFT = $clog2(DATA_SIZE_BYTES);

	////////////////////////////////////////////////////////////
	// job queue sizing
	////////////////////////////////////////////////////////////

	localparam int JOB_DEPTH = 4;
	// read / write pointer width
	localparam int JOB_PTR_BITS = $clog2(JOB_DEPTH);
	// occupancy needs one more bit to count a full queue
	localparam int JOB_CNT_BITS = $clog2(JOB_DEPTH + 1);

	// this unit's number, stamped into every command
	localparam logic [CU_BITS-1:0] CU_ID = 8'd1;

	////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////

	// one edge value from the data buffer
	typedef struct packed {
		logic                 valid;
		logic [DATA_BITS-1:0] data;
	} edge_data_t;

	// vertex to be summed, degree = number of edges to expect
	typedef struct packed {
		logic               valid;
		logic [ID_BITS-1:0] id;
		logic [ID_BITS-1:0] degree;
	} vertex_job_t;

	// work descriptor, only the result base is kept
	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] result_base;
	} wed_t;

	// status levels of a buffer
	typedef struct packed {
		logic empty;
		logic almost_full;
	} buffer_status_t;

	// accumulator to writeback
	typedef struct packed {
		logic [DATA_BITS-1:0] sum;
		logic [ID_BITS-1:0]   count;
	} accum_state_t;

	// write command toward the write buffer
	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] address;
		logic [SIZE_BITS-1:0] size;
		logic [CU_BITS-1:0]   cu_id;
		logic [ID_BITS-1:0]   vertex_id;
	} write_command_t;

	// data line that goes with the command
	typedef struct packed {
		logic                 valid;
		logic [ID_BITS-1:0]   vertex_id;
		logic [DATA_BITS-1:0] sum;
	} write_data_t;

endpackage
